// ==== all.f ====
paddle_cfg_pkg.sv
paddle_types_pkg.sv
ps2_key_decoder.sv
encoder_follower.sv
spinner_emulator.sv
paddle_control.sv
paddle_input_top.sv
tb_paddle_input.sv

// ==== encoder_follower.sv ====
// Physical AB encoder follower halving 600 pulses to a 300-pulse quadrature state
`timescale 1ns/10ps

module encoder_follower (
	input  logic                          CLK_12M,
	input  logic                          reset,
	input  logic                          enc_a,
	input  logic                          enc_b,
	output paddle_types_pkg::quad_state_e enc_state
);

	logic old_a;     // Previous A level
	logic a_change;  // Either edge of A
	logic rev;       // Direction from A vs B

	assign a_change = (enc_a != old_a);
	assign rev      = enc_a ^ enc_b;  // Differ after the edge -> reverse

	// ====================
	// Follow A edges only
	// ====================
	// B edges ignored, so one game step per half
	// physical cycle of A
	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			old_a     <= enc_a;
			enc_state <= paddle_types_pkg::quad_state_e'(paddle_cfg_pkg::QUAD_RESET);
		end else begin
			old_a <= enc_a;
			if (a_change)
				enc_state <= paddle_types_pkg::quad_step(enc_state, rev);
		end
	end

endmodule

// ==== paddle_cfg_pkg.sv ====
// Timing constants, PS/2 key codes, step sizes and reset values for the paddle front end
package paddle_cfg_pkg;

	// ====================
	// Timebase
	// ====================
	localparam int CE_DIV     = 2;      // 12 MHz / 2 -> 6 MHz strobe
	localparam int STEP_DIV   = 1500;   // Strobes per emulated encoder step
	localparam int POLL_COUNT = 48000;  // Strobes per d-pad poll, ~8 ms

	// Counter widths and terminal values
	localparam int CE_W   = $clog2(CE_DIV);
	localparam int DIV_W  = $clog2(STEP_DIV);
	localparam int POLL_W = $clog2(POLL_COUNT);

	localparam logic [CE_W-1:0]   CE_LAST   = CE_W'(CE_DIV - 1);
	localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(STEP_DIV - 1);
	localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(POLL_COUNT - 1);

	// ====================
	// Position / steps
	// ====================
	localparam int POS_W = 12;  // Signed position width

	// D-pad load magnitudes
	localparam logic [POS_W-1:0] STEP_SLOW = POS_W'(4);
	localparam logic [POS_W-1:0] STEP_FAST = POS_W'(9);

	// Idle AB level, both lines high
	localparam logic [1:0] QUAD_RESET = 2'b11;

	// ====================
	// PS/2 set 2 make codes
	// ====================
	localparam logic [7:0] KEY_START1  = 8'h16;  // 1
	localparam logic [7:0] KEY_START2  = 8'h1E;  // 2
	localparam logic [7:0] KEY_COIN1   = 8'h2E;  // 5
	localparam logic [7:0] KEY_COIN2   = 8'h36;  // 6
	localparam logic [7:0] KEY_SERVICE = 8'h46;  // 9
	localparam logic [7:0] KEY_FAST    = 8'h11;  // Alt
	localparam logic [7:0] KEY_LEFT    = 8'h6B;  // Cursor left
	localparam logic [7:0] KEY_RIGHT   = 8'h74;  // Cursor right
	localparam logic [7:0] KEY_FIRE    = 8'h29;  // Space

endpackage

// ==== paddle_control.sv ====
// Timebase, spinner source arbitration, cabinet button merge and DIP switch mapping
`timescale 1ns/10ps

module paddle_control (
	input  logic                             CLK_12M,
	input  logic                             reset,
	input  paddle_types_pkg::kbd_buttons_t   kbd,
	input  paddle_types_pkg::pad_buttons_t   pad,
	input  paddle_types_pkg::ps2_mouse_t     mouse,
	input  logic                             fire_n,
	input  logic                             enc_a,
	input  logic                             enc_b,
	input  paddle_types_pkg::game_settings_t settings,
	input  paddle_types_pkg::quad_state_e    emu_state,
	input  paddle_types_pkg::quad_state_e    enc_state,
	output paddle_types_pkg::step_cmd_t      cmd,
	output paddle_types_pkg::quad_state_e    spinner,
	output paddle_types_pkg::spin_src_e      spin_src,
	output paddle_types_pkg::cab_inputs_t    cab,
	output logic [7:0]                       dip_sw
);

	logic [paddle_cfg_pkg::CE_W-1:0]   ce_cnt;
	logic                              ce;        // 6 MHz strobe
	logic [paddle_cfg_pkg::DIV_W-1:0]  div_cnt;   // Step phase
	logic [paddle_cfg_pkg::POLL_W-1:0] poll_cnt;  // D-pad poll timer
	logic                              load_q;
	logic [paddle_cfg_pkg::POS_W-1:0]  load_val_q;
	logic [paddle_cfg_pkg::POS_W-1:0]  step_mag;

	logic m_left, m_right, m_fire, m_fast;
	logic m_start1, m_start2, m_coin1;
	logic held;  // Left or right down

	logic old_mouse_tog, old_a, old_b;
	paddle_types_pkg::spin_src_e src_q;

	// ====================
	// Button merge
	// ====================
	assign m_left   = kbd.left   | pad.left;
	assign m_right  = kbd.right  | pad.right;
	assign m_fast   = kbd.fast   | pad.fast;
	assign m_start1 = kbd.start1 | pad.start1;
	assign m_start2 = kbd.start2 | pad.start2;
	assign m_coin1  = kbd.coin1  | pad.coin1;
	assign m_fire   = kbd.fire | pad.fire | (|mouse.buttons) | ~fire_n;  // Any fire source
	assign held     = m_left | m_right;

	assign step_mag = m_fast ? paddle_cfg_pkg::STEP_FAST : paddle_cfg_pkg::STEP_SLOW;

	// ====================
	// Timebase and d-pad poll
	// ====================
	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			ce_cnt   <= '0;
			ce       <= 1'b0;
			div_cnt  <= '0;
			poll_cnt <= '0;
			load_q   <= 1'b0;
		end else begin
			ce     <= (ce_cnt == paddle_cfg_pkg::CE_LAST);
			load_q <= 1'b0;  // Single cycle pulse
			if (ce_cnt == paddle_cfg_pkg::CE_LAST)
				ce_cnt <= '0;
			else
				ce_cnt <= ce_cnt + 1'b1;

			if (ce) begin
				// Free running step divider
				if (div_cnt == paddle_cfg_pkg::DIV_LAST)
					div_cnt <= '0;
				else
					div_cnt <= div_cnt + 1'b1;

				// Emulated mouse poll while direction held
				if (held) begin
					if (poll_cnt == paddle_cfg_pkg::POLL_LAST) begin
						poll_cnt <= '0;
						load_q   <= 1'b1;
					end else begin
						poll_cnt <= poll_cnt + 1'b1;
					end
				end else begin
					poll_cnt <= '0;  // Restart on release
				end
			end
		end
	end

	// Load value, right positive
	always_ff @(posedge CLK_12M) begin
		load_val_q <= m_right ? step_mag : -step_mag;
	end

	assign cmd.strobe   = ce;
	assign cmd.step     = ce & (div_cnt == '0);
	assign cmd.load     = load_q;
	assign cmd.load_val = load_val_q;

	// ====================
	// Source arbitration
	// ====================
	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			src_q         <= paddle_types_pkg::SRC_EMULATED;
			old_mouse_tog <= mouse.toggle;
			old_a         <= enc_a;
			old_b         <= enc_b;
		end else begin
			old_mouse_tog <= mouse.toggle;
			old_a         <= enc_a;
			old_b         <= enc_b;
			if ((mouse.toggle != old_mouse_tog) || held)
				src_q <= paddle_types_pkg::SRC_EMULATED;
			if ((enc_a != old_a) || (enc_b != old_b))  // Encoder wins a tie
				src_q <= paddle_types_pkg::SRC_ENCODER;
		end
	end

	assign spin_src = src_q;
	assign spinner  = (src_q == paddle_types_pkg::SRC_ENCODER) ? enc_state : emu_state;

	// ====================
	// Cabinet and DIP
	// ====================
	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			cab <= '1;  // All released
		end else begin
			cab.coin1   <= ~m_coin1;
			cab.coin2   <= ~kbd.coin2;    // Keyboard only
			cab.shot    <= ~m_fire;
			cab.service <= ~kbd.service;  // Keyboard only
			cab.start1  <= ~m_start1;
			cab.start2  <= ~m_start2;
		end
	end

	// Continues passes straight, rest active low
	always_ff @(posedge CLK_12M) begin
		dip_sw <= {settings.continues_off, ~settings[6:0]};
	end

endmodule

// ==== paddle_input_top.sv ====
// Top level of the paddle front end connecting key decoder, control and both encoder paths
`timescale 1ns/10ps

module paddle_input_top (
	input  logic                             CLK_12M,
	input  logic                             reset,
	input  paddle_types_pkg::ps2_key_t       key,
	input  paddle_types_pkg::ps2_mouse_t     mouse,
	input  paddle_types_pkg::pad_buttons_t   pad,
	input  paddle_types_pkg::game_settings_t settings,
	input  logic                             enc_a,
	input  logic                             enc_b,
	input  logic                             fire_n,
	output paddle_types_pkg::quad_state_e    spinner,
	output paddle_types_pkg::cab_inputs_t    cab,
	output logic [7:0]                       dip_sw,
	output paddle_types_pkg::spin_src_e      spin_src
);

	paddle_types_pkg::kbd_buttons_t kbd;        // Held keys
	paddle_types_pkg::step_cmd_t    cmd;        // Strobes and d-pad load
	paddle_types_pkg::quad_state_e  emu_state;  // Emulated AB
	paddle_types_pkg::quad_state_e  enc_state;  // Followed AB

	// ====================
	// Keyboard
	// ====================
	ps2_key_decoder u_key_dec (
		.CLK_12M (CLK_12M),
		.reset   (reset),
		.key     (key),
		.kbd     (kbd)
	);

	// ====================
	// Control
	// ====================
	paddle_control u_ctrl (
		.CLK_12M   (CLK_12M),
		.reset     (reset),
		.kbd       (kbd),
		.pad       (pad),
		.mouse     (mouse),
		.fire_n    (fire_n),
		.enc_a     (enc_a),
		.enc_b     (enc_b),
		.settings  (settings),
		.emu_state (emu_state),
		.enc_state (enc_state),
		.cmd       (cmd),
		.spinner   (spinner),
		.spin_src  (spin_src),
		.cab       (cab),
		.dip_sw    (dip_sw)
	);

	// ====================
	// Encoder paths
	// ====================
	spinner_emulator u_emu (
		.CLK_12M   (CLK_12M),
		.reset     (reset),
		.cmd       (cmd),
		.mouse     (mouse),
		.emu_state (emu_state)
	);

	encoder_follower u_enc (
		.CLK_12M   (CLK_12M),
		.reset     (reset),
		.enc_a     (enc_a),
		.enc_b     (enc_b),
		.enc_state (enc_state)
	);

endmodule

// ==== paddle_types_pkg.sv ====
// Shared enums, packed structs and quadrature step function for the paddle front end
package paddle_types_pkg;

	// AB encoder levels
	typedef enum logic [1:0] {
		Q00 = 2'b00,
		Q01 = 2'b01,
		Q11 = 2'b11,  // Idle / reset
		Q10 = 2'b10
	} quad_state_e;

	// Which path feeds the game spinner
	typedef enum logic {
		SRC_EMULATED = 1'b0,
		SRC_ENCODER  = 1'b1
	} spin_src_e;

	// PS/2 key event, toggle marks a new event
	typedef struct packed {
		logic       toggle;    // [10]
		logic       pressed;   // [9] 1 = make, 0 = break
		logic       extended;  // [8] E0 prefix
		logic [7:0] code;      // [7:0]
	} ps2_key_t;

	// PS/2 mouse event, standard three-byte packet
	typedef struct packed {
		logic       toggle;    // [24]
		logic [7:0] dy;
		logic [7:0] dx;        // Low byte of X motion
		logic       y_ovf;
		logic       x_ovf;
		logic       y_sign;
		logic       x_sign;    // [4] 9th bit of dx
		logic       sync;      // Always one on the wire
		logic       middle;
		logic [1:0] buttons;   // Right, left
	} ps2_mouse_t;

	// Gamepad buttons, active high
	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic fast;
		logic start1;
		logic coin1;
		logic start2;
	} pad_buttons_t;

	// Keyboard held buttons, pad set plus coin2 and service
	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic fast;
		logic start1;
		logic coin1;
		logic start2;
		logic coin2;
		logic service;
	} kbd_buttons_t;

	// Cabinet inputs to the game, all active low
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic shot;
		logic service;
		logic start1;
		logic start2;
	} cab_inputs_t;

	// Menu DIP options, msb first
	typedef struct packed {
		logic       continues_off;
		logic       flip;
		logic       test;
		logic       difficulty;
		logic       bonus;
		logic       lives;
		logic [1:0] coinage;
	} game_settings_t;

	// Control -> emulator
	typedef struct packed {
		logic                             strobe;    // 6 MHz enable
		logic                             step;      // One per STEP_DIV strobes
		logic                             load;      // D-pad poll
		logic [paddle_cfg_pkg::POS_W-1:0] load_val;  // Signed position to load
	} step_cmd_t;

	// Next AB state; rev = 0 walks 11,01,00,10
	function automatic quad_state_e quad_step(input quad_state_e s, input logic rev);
		quad_state_e n;
		if (!rev) begin
			case (s)
				Q11:     n = Q01;
				Q01:     n = Q00;
				Q00:     n = Q10;
				default: n = Q11;  // From Q10
			endcase
		end else begin
			case (s)
				Q00:     n = Q01;
				Q01:     n = Q11;
				Q11:     n = Q10;
				default: n = Q00;  // From Q10
			endcase
		end
		return n;
	endfunction

endpackage

// ==== ps2_key_decoder.sv ====
// PS/2 key event decoder producing held keyboard button levels
`timescale 1ns/10ps

module ps2_key_decoder (
	input  logic                           CLK_12M,
	input  logic                           reset,
	input  paddle_types_pkg::ps2_key_t     key,
	output paddle_types_pkg::kbd_buttons_t kbd
);

	logic old_toggle;  // Last seen event toggle
	logic key_evt;

	// New event whenever the toggle flips
	assign key_evt = (key.toggle != old_toggle);

	// ====================
	// Held button table
	// ====================
	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			kbd        <= '0;          // Nothing held
			old_toggle <= key.toggle;  // Swallow a pending event
		end else begin
			old_toggle <= key.toggle;
			if (key_evt) begin
				// Make sets, break clears
				case (key.code)
					paddle_cfg_pkg::KEY_START1:  kbd.start1  <= key.pressed;
					paddle_cfg_pkg::KEY_START2:  kbd.start2  <= key.pressed;
					paddle_cfg_pkg::KEY_COIN1:   kbd.coin1   <= key.pressed;
					paddle_cfg_pkg::KEY_COIN2:   kbd.coin2   <= key.pressed;
					paddle_cfg_pkg::KEY_SERVICE: kbd.service <= key.pressed;

					paddle_cfg_pkg::KEY_FAST:    kbd.fast    <= key.pressed;
					paddle_cfg_pkg::KEY_LEFT:    kbd.left    <= key.pressed;
					paddle_cfg_pkg::KEY_RIGHT:   kbd.right   <= key.pressed;
					paddle_cfg_pkg::KEY_FIRE:    kbd.fire    <= key.pressed;
					default: ;  // Other keys ignored
				endcase
			end
		end
	end

endmodule

// ==== spinner_emulator.sv ====
// Signed position accumulator driving an emulated quadrature encoder toward zero
`timescale 1ns/10ps

module spinner_emulator (
	input  logic                          CLK_12M,
	input  logic                          reset,
	input  paddle_types_pkg::step_cmd_t   cmd,
	input  paddle_types_pkg::ps2_mouse_t  mouse,
	output paddle_types_pkg::quad_state_e emu_state
);

	localparam int MSB = paddle_cfg_pkg::POS_W - 1;

	logic                             old_toggle;
	logic [paddle_cfg_pkg::POS_W-1:0] pos;       // Signed, two's complement
	logic [paddle_cfg_pkg::POS_W-1:0] step_adj;  // +1, -1 or 0
	logic [paddle_cfg_pkg::POS_W-1:0] mouse_adj; // Sign extended dx
	logic [paddle_cfg_pkg::POS_W-1:0] pos_next;
	logic                             moving;
	logic                             mouse_evt;

	// Step only while distance is left
	assign moving = cmd.step && (pos != '0);

	// Skip the add near saturation
	assign mouse_evt = (mouse.toggle != old_toggle) && (pos[MSB] == pos[MSB-1]);

	// ====================
	// Position update
	// ====================
	always_comb begin
		step_adj  = '0;
		mouse_adj = '0;
		if (moving)
			step_adj = pos[MSB] ? {{(paddle_cfg_pkg::POS_W-1){1'b0}}, 1'b1} : '1;  // Toward zero
		if (mouse_evt)
			mouse_adj = {{(paddle_cfg_pkg::POS_W-8){mouse.x_sign}}, mouse.dx};
		// Both in one sum so a step is never lost to a mouse event
		pos_next = pos + step_adj + mouse_adj;
	end

	always_ff @(posedge CLK_12M) begin
		if (reset) begin
			pos        <= '0;
			old_toggle <= mouse.toggle;
			emu_state  <= paddle_types_pkg::quad_state_e'(paddle_cfg_pkg::QUAD_RESET);
		end else begin
			old_toggle <= mouse.toggle;

			// D-pad poll replaces the remaining distance
			if (cmd.load)
				pos <= cmd.load_val;
			else
				pos <= pos_next;

			// Negative position walks the reverse order
			if (moving)
				emu_state <= paddle_types_pkg::quad_step(emu_state, pos[MSB]);
		end
	end

endmodule

// ==== tb_paddle_input.sv ====
// Testbench for the paddle front end with stimulus tasks, spinner monitor and assertion checks
`timescale 1ns/10ps

module tb_paddle_input;

	localparam int STEP_PERIOD = paddle_cfg_pkg::STEP_DIV * paddle_cfg_pkg::CE_DIV;   // Cycles
	localparam int POLL_PERIOD = paddle_cfg_pkg::POLL_COUNT * paddle_cfg_pkg::CE_DIV; // Cycles

	logic                             CLK_12M;
	logic                             reset;
	paddle_types_pkg::ps2_key_t       key;
	paddle_types_pkg::ps2_mouse_t     mouse;
	paddle_types_pkg::pad_buttons_t   pad;
	paddle_types_pkg::game_settings_t settings;
	logic                             enc_a;
	logic                             enc_b;
	logic                             fire_n;
	paddle_types_pkg::quad_state_e    spinner;
	paddle_types_pkg::cab_inputs_t    cab;
	logic [7:0]                       dip_sw;
	paddle_types_pkg::spin_src_e      spin_src;

	int seed   = 32'h1243_6c6d;
	int errors = 0;
	int checks = 0;

	// Monitor state
	int                            fwd_total     = 0;
	int                            rev_total     = 0;
	int                            mon_errors    = 0;
	int                            cyc           = 0;
	int                            last_step_cyc = -STEP_PERIOD;
	paddle_types_pkg::quad_state_e prev_spin     = paddle_types_pkg::Q11;
	paddle_types_pkg::spin_src_e   prev_src      = paddle_types_pkg::SRC_EMULATED;

	paddle_input_top DUT (
		.CLK_12M  (CLK_12M),
		.reset    (reset),
		.key      (key),
		.mouse    (mouse),
		.pad      (pad),
		.settings (settings),
		.enc_a    (enc_a),
		.enc_b    (enc_b),
		.fire_n   (fire_n),
		.spinner  (spinner),
		.cab      (cab),
		.dip_sw   (dip_sw),
		.spin_src (spin_src)
	);

	initial begin
		CLK_12M = 1'b0;
		forever #4 CLK_12M = ~CLK_12M;  // 8 ns period
	end

	// ====================
	// Reference order
	// ====================
	// Forward walk 11, 01, 00, 10
	function automatic paddle_types_pkg::quad_state_e next_forward(
		input paddle_types_pkg::quad_state_e s);
		case (s)
			paddle_types_pkg::Q11: return paddle_types_pkg::Q01;
			paddle_types_pkg::Q01: return paddle_types_pkg::Q00;
			paddle_types_pkg::Q00: return paddle_types_pkg::Q10;
			default:               return paddle_types_pkg::Q11;
		endcase
	endfunction

	function automatic paddle_types_pkg::quad_state_e next_reverse(
		input paddle_types_pkg::quad_state_e s);
		case (s)
			paddle_types_pkg::Q11: return paddle_types_pkg::Q10;
			paddle_types_pkg::Q10: return paddle_types_pkg::Q00;
			paddle_types_pkg::Q00: return paddle_types_pkg::Q01;
			default:               return paddle_types_pkg::Q11;
		endcase
	endfunction

	// Counts spinner moves but not source switches
	always @(negedge CLK_12M) begin
		cyc       <= cyc + 1;
		prev_spin <= spinner;
		prev_src  <= spin_src;
		if (!reset && spin_src == prev_src && spinner != prev_spin) begin
			assert (spinner == next_forward(prev_spin) || spinner == next_reverse(prev_spin))
			else begin
				$display("Fail at %0t ns: spinner expected neighbour of %0h got %0h",
					$time, prev_spin, spinner);
				mon_errors = mon_errors + 1;
			end
			if (spinner == next_forward(prev_spin))
				fwd_total <= fwd_total + 1;
			else if (spinner == next_reverse(prev_spin))
				rev_total <= rev_total + 1;
			if (spin_src == paddle_types_pkg::SRC_EMULATED) begin
				// At most one emulated state per step period
				assert (cyc - last_step_cyc >= STEP_PERIOD) else begin
					$display("Fail at %0t ns: spinner step gap expected >= %0d got %0d",
						$time, STEP_PERIOD, cyc - last_step_cyc);
					mon_errors = mon_errors + 1;
				end
				last_step_cyc <= cyc;
			end
		end
	end

	// ====================
	// Helpers
	// ====================
	task automatic check_eq(input string sig, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			$display("Fail at %0t ns: %s expected %0h got %0h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s did not happen in time", $time, what);
		errors++;
	endtask

	task automatic tick(input int n);
		repeat (n) @(negedge CLK_12M);
	endtask

	// One key event marked by a toggle flip
	task automatic send_key(input logic [7:0] code, input logic pressed);
		key.code    = code;
		key.pressed = pressed;
		key.toggle  = ~key.toggle;
	endtask

	// dx as 9-bit two's complement
	task automatic send_mouse(input int dx);
		mouse.dx     = dx[7:0];
		mouse.x_sign = (dx < 0);
		mouse.toggle = ~mouse.toggle;
	endtask

	task automatic expect_cab(input paddle_types_pkg::cab_inputs_t exp, input int limit);
		int n;
		n = 0;
		while (cab != exp && n < limit) begin
			@(negedge CLK_12M);
			n++;
		end
		check_eq("cab", exp, cab);
	endtask

	// Make then break of one key
	task automatic press_and_release(input logic [7:0] code,
		input paddle_types_pkg::cab_inputs_t exp);
		send_key(code, 1'b1);
		expect_cab(exp, 2);
		send_key(code, 1'b0);
		expect_cab('1, 2);
	endtask

	task automatic wait_src(input paddle_types_pkg::spin_src_e exp, input int limit);
		int n;
		n = 0;
		while (spin_src != exp && n < limit) begin
			@(negedge CLK_12M);
			n++;
		end
		check_eq("spin_src", exp, spin_src);
	endtask

	// Waits until target moves past the base counts
	task automatic wait_moves(input int fb, input int rb, input int target, input int limit,
		input string what);
		int n;
		n = 0;
		while ((fwd_total - fb) + (rev_total - rb) < target && n < limit) begin
			@(negedge CLK_12M);
			n++;
		end
		if ((fwd_total - fb) + (rev_total - rb) < target)
			report_timeout(what);
	endtask

	task automatic check_moves(input int fb, input int rb, input int exp_f, input int exp_r);
		check_eq("spinner forward steps", exp_f, fwd_total - fb);
		check_eq("spinner reverse steps", exp_r, rev_total - rb);
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin : main
		paddle_types_pkg::cab_inputs_t exp_cab;
		int                            dx;
		int                            mag;
		int                            fb;
		int                            rb;
		int                            exp_f;
		int                            exp_r;
		int                            i;
		logic [7:0]                    s;
		logic [1:0]                    ab_seq [0:6];

		key      = '0;
		mouse    = '0;
		mouse.sync = 1'b1;
		pad      = '0;
		settings = '0;
		enc_a    = 1'b1;  // Encoder idles at 11
		enc_b    = 1'b1;
		fire_n   = 1'b1;
		reset    = 1'b1;
		repeat (8) @(posedge CLK_12M);  // Eight reset cycles
		@(negedge CLK_12M);
		reset = 1'b0;
		tick(1);

		// Reset values
		check_eq("spinner", paddle_types_pkg::Q11, spinner);
		check_eq("cab", 6'h3F, cab);
		check_eq("spin_src", paddle_types_pkg::SRC_EMULATED, spin_src);

		// Keyboard buttons with 2 cycle latency
		exp_cab        = '1;
		exp_cab.start1 = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_START1, exp_cab);
		exp_cab        = '1;
		exp_cab.start2 = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_START2, exp_cab);
		exp_cab        = '1;
		exp_cab.coin1  = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_COIN1, exp_cab);
		exp_cab        = '1;
		exp_cab.coin2  = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_COIN2, exp_cab);
		exp_cab         = '1;
		exp_cab.service = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_SERVICE, exp_cab);

		// Pad start and coin buttons
		exp_cab        = '1;
		exp_cab.start1 = 1'b0;
		exp_cab.coin1  = 1'b0;
		exp_cab.start2 = 1'b0;
		pad.start1     = 1'b1;
		pad.coin1      = 1'b1;
		pad.start2     = 1'b1;
		expect_cab(exp_cab, 2);
		pad = '0;
		expect_cab('1, 2);

		// Each shot source in turn
		exp_cab      = '1;
		exp_cab.shot = 1'b0;
		press_and_release(paddle_cfg_pkg::KEY_FIRE, exp_cab);
		pad.fire = 1'b1;
		expect_cab(exp_cab, 2);
		pad.fire = 1'b0;
		expect_cab('1, 2);
		mouse.buttons = 2'b01;  // Left button without an event
		expect_cab(exp_cab, 2);
		mouse.buttons = 2'b00;
		expect_cab('1, 2);
		fire_n = 1'b0;
		expect_cab(exp_cab, 2);
		fire_n = 1'b1;
		expect_cab('1, 2);

		// DIP msb passes and the low seven bits invert
		for (i = 0; i < 8; i++) begin
			s        = $random(seed);
			settings = s;
			tick(1);
			check_eq("dip_sw", s ^ 8'h7F, dip_sw);
		end

		// ====================
		// Mouse stepping
		// ====================
		for (i = 0; i < 3; i++) begin
			dx = $random(seed) % 21;
			if (dx == 0)
				dx = 7;
			mag = (dx < 0) ? -dx : dx;
			fb  = fwd_total;
			rb  = rev_total;
			send_mouse(dx);
			wait_moves(fb, rb, mag, (mag + 2) * STEP_PERIOD, "mouse stepping");
			tick(2 * STEP_PERIOD);  // Must hold here
			check_moves(fb, rb, (dx > 0) ? mag : 0, (dx < 0) ? mag : 0);
		end

		// D-pad right at slow speed
		fb        = fwd_total;
		rb        = rev_total;
		pad.right = 1'b1;
		wait_moves(fb, rb, 1, POLL_PERIOD + 2 * STEP_PERIOD, "first right step");
		pad.right = 1'b0;
		mag = int'(paddle_cfg_pkg::STEP_SLOW);
		wait_moves(fb, rb, mag, (mag + 2) * STEP_PERIOD, "right stepping");
		tick(2 * STEP_PERIOD);
		check_moves(fb, rb, mag, 0);

		// Keyboard left with fast
		fb = fwd_total;
		rb = rev_total;
		send_key(paddle_cfg_pkg::KEY_FAST, 1'b1);
		tick(1);
		send_key(paddle_cfg_pkg::KEY_LEFT, 1'b1);
		wait_moves(fb, rb, 1, POLL_PERIOD + 2 * STEP_PERIOD, "first left step");
		send_key(paddle_cfg_pkg::KEY_LEFT, 1'b0);
		tick(1);
		send_key(paddle_cfg_pkg::KEY_FAST, 1'b0);
		mag = int'(paddle_cfg_pkg::STEP_FAST);
		wait_moves(fb, rb, mag, (mag + 2) * STEP_PERIOD, "left stepping");
		tick(2 * STEP_PERIOD);
		check_moves(fb, rb, 0, mag);

		// ====================
		// Physical encoder
		// ====================
		enc_b = 1'b0;  // B edge alone leaves the follower at Q11
		wait_src(paddle_types_pkg::SRC_ENCODER, 4);
		tick(2);
		fb     = fwd_total;
		rb     = rev_total;
		exp_f  = 0;
		exp_r  = 0;
		ab_seq = '{2'b00, 2'b01, 2'b11, 2'b01, 2'b00, 2'b10, 2'b11};  // {a, b}
		for (i = 0; i < 7; i++) begin
			if (ab_seq[i][1] != enc_a) begin
				if (ab_seq[i][1] != ab_seq[i][0])
					exp_r++;  // A and B differ
				else
					exp_f++;
			end
			enc_a = ab_seq[i][1];
			enc_b = ab_seq[i][0];
			wait_moves(fb, rb, exp_f + exp_r, 3, "encoder follow");
			tick(2);
			check_moves(fb, rb, exp_f, exp_r);
		end

		// Mouse takes the spinner back
		fb = fwd_total;
		rb = rev_total;
		send_mouse(3);
		wait_src(paddle_types_pkg::SRC_EMULATED, 4);
		wait_moves(fb, rb, 3, 5 * STEP_PERIOD, "mouse after encoder");
		tick(2 * STEP_PERIOD);
		check_moves(fb, rb, 3, 0);

		errors = errors + mon_errors;
		$display("Checks: %0d, errors: %0d, forward steps: %0d, reverse steps: %0d",
			checks, errors, fwd_total, rev_total);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
